// File: adpcma_pkg.sv
// shared constants and tables; six channels fixed, index_adj top entries saturate at +7
package adpcma_pkg;
    localparam int num_ch = 6;  // channels sharing one datapath
    localparam int rom_aw = 24; // byte address into the sample rom
    localparam int acc_w  = 12; // decoder accumulator, signed
    localparam int snd_w  = 16; // mixed output, signed

    // reg_addr[5:3] picks the field, reg_addr[2:0] the channel
    localparam logic [2:0] fld_key      = 3'd0; // channel bits ignored here
    localparam logic [2:0] fld_pan      = 3'd1;
    localparam logic [2:0] fld_start_lo = 3'd2;
    localparam logic [2:0] fld_start_hi = 3'd3;
    localparam logic [2:0] fld_end_lo   = 3'd4;
    localparam logic [2:0] fld_end_hi   = 3'd5;

    // step size per index, roughly x1.1 per entry
    localparam logic [11:0] step_table [0:48] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,   12'd31,
        12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,   12'd60,   12'd66,
        12'd73,   12'd80,   12'd88,   12'd97,   12'd107,  12'd118,  12'd130,  12'd143,
        12'd157,  12'd173,  12'd190,  12'd209,  12'd230,  12'd253,  12'd279,  12'd307,
        12'd337,  12'd371,  12'd408,  12'd449,  12'd494,  12'd544,  12'd598,  12'd658,
        12'd724,  12'd796,  12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411,
        12'd1552
    };
    // index move by nibble magnitude
    localparam logic signed [3:0] index_adj [0:7] = '{
        -4'sd1, -4'sd1, -4'sd1, -4'sd1, 4'sd2, 4'sd4, 4'sd6, 4'sd7
    };

    typedef struct packed {
        logic       dump; // 1 = key off
        logic       rsvd;
        logic [5:0] mask; // one bit per channel
    } key_view_t;
    typedef struct packed {
        logic       left;
        logic       right;
        logic [5:0] level; // gain is (level+1)/64
    } pan_view_t;
    typedef union packed {
        key_view_t key; // fld_key writes
        pan_view_t pan; // fld_pan writes
    } reg_word_u;
endpackage

// File: adpcma_addr_gen.sv
// end block must not be below start block; after key-on the first fetch comes one visit later
module adpcma_addr_gen import adpcma_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic              reg_wr,
    input  logic [5:0]        reg_addr,
    input  logic [7:0]        reg_data,
    output logic [rom_aw-1:0] rom_addr,
    output logic              roe_n,
    output logic [5:0]        end_flags,
    output logic [2:0]        fetch_slot,
    output logic              fetch_on,
    output logic              fetch_first,
    output logic              fetch_low
);
    logic [15:0]       start_r [num_ch]; // 256-byte blocks
    logic [15:0]       end_r   [num_ch];
    logic [rom_aw-1:0] cur     [num_ch]; // byte now playing
    logic [num_ch-1:0] active;
    logic [num_ch-1:0] phase;            // 1 = low nibble on next visit
    logic [num_ch-1:0] first;
    logic [num_ch-1:0] on_pend;          // key commands waiting for their slot
    logic [num_ch-1:0] off_pend;
    logic [num_ch-1:0] slot_hit, key_mask, on_set, off_set;
    logic [2:0]        slot;
    reg_word_u         wr_word;
    logic              wr_ch_ok, load, go, at_end;

    assign wr_word  = reg_data;
    assign wr_ch_ok = reg_addr[2:0] < 3'(num_ch);
    assign key_mask = (reg_wr && reg_addr[5:3] == fld_key) ? wr_word.key.mask : '0;
    assign on_set   = wr_word.key.dump ? '0 : key_mask;
    assign off_set  = wr_word.key.dump ? key_mask : '0;
    assign slot_hit = cen ? num_ch'(1) << slot : '0;

    assign load   = cen && on_pend[slot];                                    // key-on lands
    assign go     = cen && active[slot] && !on_pend[slot] && !off_pend[slot]; // real fetch
    assign at_end = cur[slot] == {end_r[slot], 8'hff};

    always_ff @(posedge clk) begin
        if (reg_wr && wr_ch_ok) begin
            case (reg_addr[5:3])
                fld_start_lo: start_r[reg_addr[2:0]][7:0]  <= reg_data;
                fld_start_hi: start_r[reg_addr[2:0]][15:8] <= reg_data;
                fld_end_lo:   end_r[reg_addr[2:0]][7:0]    <= reg_data;
                fld_end_hi:   end_r[reg_addr[2:0]][15:8]   <= reg_data;
                default: ;
            endcase
        end
        if (load)
            cur[slot] <= {start_r[slot], 8'h00};
        else if (go && phase[slot] && !at_end)
            cur[slot] <= cur[slot] + rom_aw'(1); // step after the low nibble
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot        <= '0;
            active      <= '0;
            phase       <= '0;
            first       <= '0;
            on_pend     <= '0;
            off_pend    <= '0;
            end_flags   <= '0;
            rom_addr    <= '0;
            roe_n       <= 1'b1;
            fetch_slot  <= '0;
            fetch_on    <= 1'b0;
            fetch_first <= 1'b0;
            fetch_low   <= 1'b0;
        end else begin
            if (cen) begin
                slot        <= (slot == 3'(num_ch - 1)) ? 3'd0 : slot + 3'd1;
                fetch_slot  <= slot;      // tag travels with the fetch
                fetch_on    <= go;
                fetch_first <= go && first[slot];
                fetch_low   <= go && phase[slot];
                roe_n       <= !go;
            end
            if (go)
                rom_addr <= cur[slot];
            if (load) begin
                active[slot]    <= 1'b1;
                phase[slot]     <= 1'b0;
                first[slot]     <= 1'b1;
                end_flags[slot] <= 1'b0;
            end else if (cen && off_pend[slot]) begin
                active[slot] <= 1'b0;     // key off keeps phase and address
            end else if (go) begin
                first[slot] <= 1'b0;
                phase[slot] <= !phase[slot];
                if (phase[slot] && at_end) begin
                    active[slot]    <= 1'b0;
                    end_flags[slot] <= 1'b1;
                end
            end
            // pend bits clear at their slot and the newest write wins
            on_pend  <= (on_pend & ~slot_hit & ~off_set) | on_set;
            off_pend <= (off_pend & ~slot_hit & ~on_set) | off_set;
        end
    end

    // a playing address never runs past its end block
    a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        go |-> cur[slot] <= {end_r[slot], 8'hff});
endmodule

// File: adpcma_nibble_buf.sv
// rom_data is sampled on the cen after the address went out; rom must answer within one slot
module adpcma_nibble_buf (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic [7:0] rom_data,
    input  logic [2:0] fetch_slot,
    input  logic       fetch_on,
    input  logic       fetch_first,
    input  logic       fetch_low,
    output logic [3:0] nib,
    output logic [2:0] nib_slot,
    output logic       nib_on,
    output logic       nib_first
);
    logic [7:0] data_q; // rom byte for the slot in nib_slot
    logic       low_q;

    always_ff @(posedge clk) begin
        if (cen)
            data_q <= rom_data;
    end

    // slot tags one stage on, lined up with the byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nib_slot  <= '0;
            nib_on    <= 1'b0;
            nib_first <= 1'b0;
            low_q     <= 1'b0;
        end else if (cen) begin
            nib_slot  <= fetch_slot;
            nib_on    <= fetch_on;
            nib_first <= fetch_first;
            low_q     <= fetch_low;
        end
    end

    // high nibble plays first, idle slot reads as 0
    assign nib = !nib_on ? 4'd0 : (low_q ? data_q[3:0] : data_q[7:4]);
endmodule

// File: adpcma_decoder.sv
// state of idle slots is kept untouched; nib_first restarts a channel from zero
module adpcma_decoder import adpcma_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cen,
    input  logic [3:0]              nib,
    input  logic [2:0]              nib_slot,
    input  logic                    nib_on,
    input  logic                    nib_first,
    output logic signed [acc_w-1:0] dec_sample,
    output logic [2:0]              dec_slot,
    output logic                    dec_on
);
    logic signed [acc_w-1:0] acc [num_ch]; // per-channel sample
    logic [5:0]              idx [num_ch]; // per-channel step index
    logic signed [acc_w-1:0] acc_cur, acc_nxt;
    logic [5:0]              idx_cur, idx_nxt;
    logic [11:0]             step;
    logic [2:0]              mag;
    logic [15:0]             prod;     // step * (2m+1)
    logic [12:0]             diff;
    logic signed [acc_w+1:0] acc_ext, diff_ext, sum; // room past both rails
    logic signed [6:0]       idx_sum;

    always_comb begin
        acc_cur  = nib_first ? '0 : acc[nib_slot];
        idx_cur  = nib_first ? '0 : idx[nib_slot];
        mag      = nib[2:0];
        step     = step_table[idx_cur];
        prod     = {4'd0, step} * {12'd0, mag, 1'b1};
        diff     = prod[15:3];                  // divide by 8
        acc_ext  = acc_cur;                     // sign extends
        diff_ext = {1'b0, diff};
        sum      = nib[3] ? acc_ext - diff_ext : acc_ext + diff_ext;
        if (sum > 14'sd2047)
            acc_nxt = 12'sh7ff;
        else if (sum < -14'sd2048)
            acc_nxt = 12'sh800;
        else
            acc_nxt = sum[acc_w-1:0];
        idx_sum = $signed({1'b0, idx_cur}) + index_adj[mag];
        if (idx_sum < 7'sd0)
            idx_nxt = 6'd0;
        else if (idx_sum > 7'sd48)
            idx_nxt = 6'd48;
        else
            idx_nxt = idx_sum[5:0];
    end

    always_ff @(posedge clk) begin
        if (cen && nib_on) begin
            acc[nib_slot] <= acc_nxt;
            idx[nib_slot] <= idx_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_sample <= '0;
            dec_slot   <= '0;
            dec_on     <= 1'b0;
        end else if (cen) begin
            dec_sample <= nib_on ? acc_nxt : '0; // idle slot mixes as 0
            dec_slot   <= nib_slot;
            dec_on     <= nib_on;
        end
    end

    // a restart must carry a real nibble or the clear is lost
    a_first_on: assert property (@(posedge clk) disable iff (!rst_n)
        nib_first |-> nib_on);
    // slot tag from the address generator wraps at num_ch
    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        nib_slot < 3'(num_ch));
endmodule

// File: adpcma_mixer.sv
// pan writes take effect at once, so a change mid-round shows partly in that round's sum
module adpcma_mixer import adpcma_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cen,
    input  logic                    reg_wr,
    input  logic [5:0]              reg_addr,
    input  logic [7:0]              reg_data,
    input  logic signed [acc_w-1:0] dec_sample,
    input  logic [2:0]              dec_slot,
    input  logic                    dec_on,
    output logic signed [snd_w-1:0] snd_l,
    output logic signed [snd_w-1:0] snd_r,
    output logic                    snd_valid
);
    logic [num_ch-1:0]       en_l, en_r;
    logic [5:0]              level [num_ch];
    reg_word_u               wr_word;
    logic                    pan_wr;
    logic signed [acc_w+7:0] prod, shifted;  // 12 x 8 bits
    logic signed [snd_w-1:0] contrib, add_l, add_r;
    logic signed [snd_w-1:0] sum_l, sum_r, nxt_l, nxt_r; // running round sums

    assign wr_word = reg_data;
    assign pan_wr  = reg_wr && reg_addr[5:3] == fld_pan && reg_addr[2:0] < 3'(num_ch);

    always_comb begin
        prod    = dec_sample * $signed({2'b00, level[dec_slot]} + 8'd1);
        shifted = prod >>> 6;
        contrib = shifted[snd_w-1:0];          // |contrib| <= 2048
        add_l   = (dec_on && en_l[dec_slot]) ? contrib : '0;
        add_r   = (dec_on && en_r[dec_slot]) ? contrib : '0;
        nxt_l   = sum_l + add_l;
        nxt_r   = sum_r + add_r;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_l      <= '0;
            en_r      <= '0;
            sum_l     <= '0;
            sum_r     <= '0;
            snd_l     <= '0;
            snd_r     <= '0;
            snd_valid <= 1'b0;
            for (int i = 0; i < num_ch; i++)
                level[i] <= '0;
        end else begin
            snd_valid <= 1'b0;
            if (pan_wr) begin
                en_l[reg_addr[2:0]]  <= wr_word.pan.left;
                en_r[reg_addr[2:0]]  <= wr_word.pan.right;
                level[reg_addr[2:0]] <= wr_word.pan.level;
            end
            if (cen) begin
                if (dec_slot == 3'(num_ch - 1)) begin
                    snd_l     <= nxt_l;       // publish with slot 5 folded in
                    snd_r     <= nxt_r;
                    sum_l     <= '0;
                    sum_r     <= '0;
                    snd_valid <= 1'b1;
                end else begin
                    sum_l <= nxt_l;
                    sum_r <= nxt_r;
                end
            end
        end
    end

    // one pulse per round
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        snd_valid |=> !snd_valid);
endmodule

// File: adpcma_top.sv
// cen paces every stage, one slot per pulse; rom data is due by the next pulse
module adpcma_top import adpcma_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cen,
    input  logic                    reg_wr,
    input  logic [5:0]              reg_addr,
    input  logic [7:0]              reg_data,
    input  logic [7:0]              rom_data,
    output logic [rom_aw-1:0]       rom_addr,
    output logic                    roe_n,
    output logic [5:0]              end_flags,
    output logic signed [snd_w-1:0] snd_l,
    output logic signed [snd_w-1:0] snd_r,
    output logic                    snd_valid
);
    logic [2:0]              fetch_slot, nib_slot, dec_slot;
    logic                    fetch_on, fetch_first, fetch_low;
    logic [3:0]              nib;
    logic                    nib_on, nib_first, dec_on;
    logic signed [acc_w-1:0] dec_sample;

    adpcma_addr_gen u_addr_gen (
        .clk, .rst_n, .cen, .reg_wr, .reg_addr, .reg_data,
        .rom_addr, .roe_n, .end_flags,
        .fetch_slot, .fetch_on, .fetch_first, .fetch_low
    );

    adpcma_nibble_buf u_nibble_buf (
        .clk, .rst_n, .cen, .rom_data,
        .fetch_slot, .fetch_on, .fetch_first, .fetch_low,
        .nib, .nib_slot, .nib_on, .nib_first
    );

    adpcma_decoder u_decoder (
        .clk, .rst_n, .cen, .nib, .nib_slot, .nib_on, .nib_first,
        .dec_sample, .dec_slot, .dec_on
    );

    adpcma_mixer u_mixer (
        .clk, .rst_n, .cen, .reg_wr, .reg_addr, .reg_data,
        .dec_sample, .dec_slot, .dec_on,
        .snd_l, .snd_r, .snd_valid
    );
endmodule

// File: tb_adpcma.sv
// model expects one idle visit after key-on and three cen pulses from issue to mix; rom is 256 bytes xor upper address
module tb_adpcma import adpcma_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [2:0]  ch;
        logic [15:0] start_blk, end_blk;
        logic [9:0]  rounds;     // snd_valid pulses to wait, 0 = writes only
        logic [7:0]  pan;        // left, right, level
        logic [1:0]  key;        // 0 none, 1 on, 2 off
        logic [5:0]  exp_on;     // slots fetching in the last round
    } row_t;

    logic                    clk, rst_n, cen, reg_wr, roe_n, snd_valid, exp_roe_n, exp_valid;
    logic [5:0]              reg_addr, end_flags, active, phase, first, on_pend, off_pend;
    logic [5:0]              pan_l, pan_r, ref_flags, seen, seen_last;
    logic [7:0]              reg_data, rom_data;
    logic [rom_aw-1:0]       rom_addr;
    logic signed [snd_w-1:0] snd_l, snd_r;
    logic [7:0]              rom_mem [256];
    logic [15:0]             ref_start [num_ch], ref_end [num_ch];
    int                      cur [num_ch], acc [num_ch], idx [num_ch], lvl [num_ch];
    int                      q_slot [$], q_smp [$];  // decoded, waiting for the mixer
    int                      slot, last_slot, sum_l, sum_r, exp_l, exp_r, exp_addr;
    int                      errors, rounds, limit;
    row_t                    rows [8];

    adpcma_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? (s >> 1) ^ 16'hb400 : s >> 1;
    endfunction

    function automatic logic [7:0] rom_byte(input logic [rom_aw-1:0] a);
        return rom_mem[a[7:0]] ^ a[15:8] ^ a[23:16]; // block number folds in
    endfunction

    // sign plus magnitude, diff = step*(2m+1)/8, both clamps
    function automatic int decode_nibble(input int ch, input logic [3:0] n);
        int diff;
        diff = int'(step_table[idx[ch]]) * (2 * int'(n[2:0]) + 1) / 8;
        acc[ch] = n[3] ? acc[ch] - diff : acc[ch] + diff;
        if (acc[ch] > 2047) acc[ch] = 2047;
        if (acc[ch] < -2048) acc[ch] = -2048;
        idx[ch] = idx[ch] + int'(index_adj[n[2:0]]);
        if (idx[ch] < 0) idx[ch] = 0;
        if (idx[ch] > 48) idx[ch] = 48;
        return acc[ch];
    endfunction

    task automatic report_mismatch(input string name, input int exp_v, input int got_v);
        errors++;
        $display("Fail %0t %s exp %0d got %0d", $time, name, exp_v, got_v);
    endtask

    task automatic issue_slot();
        logic [7:0] b;
        int         smp;
        smp       = 0;
        exp_roe_n = 1'b1;
        if (on_pend[slot]) begin         // key-on lands, fetch starts next visit
            cur[slot]       = int'(ref_start[slot]) * 256;
            active[slot]    = 1'b1;
            phase[slot]     = 1'b0;
            first[slot]     = 1'b1;
            ref_flags[slot] = 1'b0;
        end else if (off_pend[slot]) begin
            active[slot] = 1'b0;
        end else if (active[slot]) begin
            exp_roe_n = 1'b0;
            exp_addr  = cur[slot];
            b         = rom_byte(cur[slot]);
            if (first[slot]) begin       // fresh decoder state
                acc[slot] = 0;
                idx[slot] = 0;
            end
            smp         = decode_nibble(slot, phase[slot] ? b[3:0] : b[7:4]);
            first[slot] = 1'b0;
            if (phase[slot] && cur[slot] == int'(ref_end[slot]) * 256 + 255) begin
                active[slot]    = 1'b0;
                ref_flags[slot] = 1'b1;
            end else if (phase[slot]) begin
                cur[slot]++;             // next byte after the low nibble
            end
            phase[slot] = !phase[slot];
        end
        on_pend[slot]  = 1'b0;
        off_pend[slot] = 1'b0;
        q_slot.push_back(slot);
        q_smp.push_back(smp);
        last_slot = slot;
        slot      = (slot + 1) % num_ch;
    endtask

    task automatic mix_slot();
        int ch, smp, part;
        ch   = q_slot.pop_front();       // issued three pulses ago
        smp  = q_smp.pop_front();
        part = (smp * (lvl[ch] + 1)) >>> 6;
        if (pan_l[ch]) sum_l += part;
        if (pan_r[ch]) sum_r += part;
        if (ch == num_ch - 1) begin      // round complete
            exp_l     = sum_l;
            exp_r     = sum_r;
            sum_l     = 0;
            sum_r     = 0;
            exp_valid = 1'b1;
        end
    endtask

    task automatic track_reg_write();
        int ch;
        ch = int'(reg_addr[2:0]);
        if (reg_addr[5:3] == fld_key) begin
            if (reg_data[7]) begin       // dump bit, key off
                off_pend = off_pend | reg_data[5:0];
                on_pend  = on_pend & ~reg_data[5:0];
            end else begin
                on_pend  = on_pend | reg_data[5:0];
                off_pend = off_pend & ~reg_data[5:0];
            end
        end else if (ch < num_ch) begin
            case (reg_addr[5:3])
                fld_pan: begin
                    pan_l[ch] = reg_data[7];
                    pan_r[ch] = reg_data[6];
                    lvl[ch]   = int'(reg_data[5:0]);
                end
                fld_start_lo: ref_start[ch][7:0]  = reg_data;
                fld_start_hi: ref_start[ch][15:8] = reg_data;
                fld_end_lo:   ref_end[ch][7:0]    = reg_data;
                fld_end_hi:   ref_end[ch][15:8]   = reg_data;
                default: ;
            endcase
        end
    endtask

    // checks use pre-edge values, model then steps for this edge
    always @(posedge clk) begin
        rom_data <= rom_byte(rom_addr); // ready one clock before the sampling cen
        cen      <= rst_n && !cen;      // every second clock
        if (rst_n) begin
            if (snd_valid !== exp_valid) report_mismatch("snd_valid", exp_valid, snd_valid);
            if (snd_l !== exp_l) report_mismatch("snd_l", exp_l, snd_l);
            if (snd_r !== exp_r) report_mismatch("snd_r", exp_r, snd_r);
            if (roe_n !== exp_roe_n) report_mismatch("roe_n", exp_roe_n, roe_n);
            if (!exp_roe_n && rom_addr !== exp_addr[rom_aw-1:0])
                report_mismatch("rom_addr", exp_addr, rom_addr);
            if (end_flags !== ref_flags) report_mismatch("end_flags", ref_flags, end_flags);
            if (!roe_n) seen[last_slot] = 1'b1;
            if (snd_valid) begin
                rounds++;
                seen_last = seen;
                seen      = '0;
            end
            exp_valid = 1'b0;
            if (cen) begin
                issue_slot();
                mix_slot();
            end
            if (reg_wr) track_reg_write();
        end
    end

    task automatic write_reg(input logic [5:0] a, input logic [7:0] d);
        @(posedge clk);
        reg_wr   <= 1'b1;
        reg_addr <= a;
        reg_data <= d;
        @(posedge clk);
        reg_wr   <= 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        write_reg({fld_start_lo, r.ch}, r.start_blk[7:0]);
        write_reg({fld_start_hi, r.ch}, r.start_blk[15:8]);
        write_reg({fld_end_lo, r.ch}, r.end_blk[7:0]);
        write_reg({fld_end_hi, r.ch}, r.end_blk[15:8]);
        write_reg({fld_pan, r.ch}, r.pan);
        if (r.key != 2'd0)
            write_reg({fld_key, 3'd0}, {r.key == 2'd2, 1'b0, 6'(1 << r.ch)});
    endtask

    initial begin
        logic [15:0] lfsr;
        {rst_n, cen, reg_wr, reg_addr, reg_data, rom_data} = '0;
        {active, phase, first, on_pend, off_pend, pan_l, pan_r, ref_flags} = '0;
        {seen, seen_last, exp_valid, exp_roe_n} = 14'b1;
        {slot, last_slot, sum_l, sum_r, exp_l, exp_r, exp_addr, errors, rounds} = '0;
        foreach (lvl[i]) {lvl[i], acc[i], idx[i], cur[i]} = '0;
        q_slot = '{0, 0, 0};             // pipeline holds slot 0 out of reset
        q_smp  = '{0, 0, 0};
        lfsr   = 16'd47031;
        foreach (rom_mem[a]) begin
            for (int b = 0; b < 8; b++) begin
                rom_mem[a][b] = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end
        end
        // ch, start, end, rounds, pan, key, slots fetching at the end
        rows[0] = '{3'd0, 16'd2, 16'd2, 10'd4, 8'hff, 2'd1, 6'b000001};   // full level, both
        rows[1] = '{3'd0, 16'd2, 16'd2, 10'd3, 8'hbf, 2'd0, 6'b000001};   // left only
        rows[2] = '{3'd0, 16'd2, 16'd2, 10'd3, 8'h94, 2'd0, 6'b000001};   // level 20
        rows[3] = '{3'd0, 16'd2, 16'd2, 10'd3, 8'h94, 2'd2, 6'b000000};   // key off mid sample
        rows[4] = '{3'd0, 16'd2, 16'd2, 10'd520, 8'hff, 2'd1, 6'b000000}; // restart, play to end
        rows[5] = '{3'd1, 16'd5, 16'd6, 10'd0, 8'ha8, 2'd1, 6'b000000};
        rows[6] = '{3'd3, 16'd9, 16'd9, 10'd0, 8'h4a, 2'd1, 6'b000000};
        rows[7] = '{3'd4, 16'd0, 16'd1, 10'd40, 8'hdf, 2'd1, 6'b011010}; // three-way mix
        limit = 200;
        foreach (rows[i]) limit += int'(rows[i].rounds) * num_ch * 2;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            if (rows[i].rounds != 0) begin
                repeat (rows[i].rounds) begin
                    do @(posedge clk); while (snd_valid !== 1'b1);
                end
                @(posedge clk);          // seen_last settled at the valid edge
                if (seen_last !== rows[i].exp_on)
                    report_mismatch("fetching slots", rows[i].exp_on, seen_last);
            end
        end
        $display("%0d rounds checked, %0d errors", rounds, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still going after %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end
endmodule

// File: all.f
adpcma_pkg.sv
adpcma_addr_gen.sv
adpcma_nibble_buf.sv
adpcma_decoder.sv
adpcma_mixer.sv
adpcma_top.sv
tb_adpcma.sv

// File: Makefile
# Verilator flow for tb_adpcma; all variables can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= tb_adpcma
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
